//--- rtl/rv_id_pkg.sv
package rv_id_pkg;

	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;
	localparam int NUM_REGS   = 32;

	typedef logic [XLEN-1:0]       word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	localparam reg_addr_t LINK_REG = 5'd1; // ra

	// major opcodes, inst[6:0]
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;

	// alu funct3, same for register and immediate forms
	localparam logic [2:0] F3_ADD  = 3'b000; // also SUB
	localparam logic [2:0] F3_SLL  = 3'b001;
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_SRL  = 3'b101; // also SRA
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;

	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	localparam logic [2:0] F3_LB  = 3'b000;
	localparam logic [2:0] F3_LH  = 3'b001;
	localparam logic [2:0] F3_LW  = 3'b010;
	localparam logic [2:0] F3_LBU = 3'b100;
	localparam logic [2:0] F3_LHU = 3'b101;
	localparam logic [2:0] F3_SB  = 3'b000;
	localparam logic [2:0] F3_SH  = 3'b001;
	localparam logic [2:0] F3_SW  = 3'b010;
	localparam logic [2:0] F3_JALR = 3'b000;

	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000; // SUB, SRA, SRAI

	typedef enum logic [5:0] {
		ALU_NOP = 6'd0,
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
		ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
		ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU,
		ALU_JAL, ALU_JALR,
		ALU_LB, ALU_LH, ALU_LW, ALU_LBU, ALU_LHU,
		ALU_SB, ALU_SH, ALU_SW
	} aluop_t;

	typedef enum logic [2:0] {
		SEL_NOP = 3'd0,
		SEL_LOGIC,
		SEL_SHIFT,
		SEL_ARITH,
		SEL_JUMP_BRANCH,
		SEL_LOAD_STORE
	} alusel_t;

	// nine kinds, so one bit wider than the result class
	typedef enum logic [3:0] {
		BR_NONE = 4'd0,
		BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU,
		BR_JAL, BR_JALR
	} br_kind_t;

	function automatic logic is_load(input aluop_t op);
		return op inside {ALU_LB, ALU_LH, ALU_LW, ALU_LBU, ALU_LHU};
	endfunction

endpackage

//--- rtl/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder import rv_id_pkg::*; (
	input  word_t     pc_i,
	input  word_t     inst_i,
	output aluop_t    aluop_o,
	output alusel_t   alusel_o,
	output reg_addr_t wd_o,
	output logic      wreg_o,
	output logic      illegal_o,
	output logic      reg1_read_o,
	output logic      reg2_read_o,
	output reg_addr_t reg1_addr_o,
	output reg_addr_t reg2_addr_o,
	output word_t     reg1_alt_o,
	output word_t     reg2_alt_o,
	output br_kind_t  br_kind_o,
	output word_t     br_offset_o
);

	logic [6:0] opcode;
	logic [6:0] funct7;
	logic [2:0] funct3;
	logic       f7_alt;
	logic       is_shift;
	logic       r_legal;
	logic       i_legal;
	logic       legal;
	aluop_t     alu_op;
	alusel_t    alu_sel;
	word_t      imm_i;
	word_t      imm_sh;
	word_t      imm_b;
	word_t      imm_u;
	word_t      imm_j;

	assign opcode = inst_i[6:0];
	assign funct3 = inst_i[14:12];
	assign funct7 = inst_i[31:25];

	assign imm_i  = {{20{inst_i[31]}}, inst_i[31:20]};
	assign imm_sh = word_t'(inst_i[24:20]); // shamt, zero extended
	assign imm_b  = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
	assign imm_u  = {inst_i[31:12], 12'b0};
	assign imm_j  = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

	assign f7_alt   = (funct7 == F7_ALT);
	assign is_shift = (funct3 == F3_SLL) || (funct3 == F3_SRL);
	// anything else in funct7 (M extension among it) is illegal
	assign r_legal  = (funct7 == F7_BASE) || (f7_alt && (funct3 == F3_ADD || funct3 == F3_SRL));
	assign i_legal  = !is_shift || (funct7 == F7_BASE) || (f7_alt && funct3 == F3_SRL);

	// alu op shared by OP and OP-IMM
	always_comb begin
		alu_op  = ALU_NOP;
		alu_sel = SEL_NOP;
		case (funct3)
			F3_ADD: begin
				alu_op  = (f7_alt && opcode == OPC_OP) ? ALU_SUB : ALU_ADD; // no SUBI
				alu_sel = SEL_ARITH;
			end
			F3_SLL: begin
				alu_op  = ALU_SLL;
				alu_sel = SEL_SHIFT;
			end
			F3_SLT: begin
				alu_op  = ALU_SLT;
				alu_sel = SEL_ARITH;
			end
			F3_SLTU: begin
				alu_op  = ALU_SLTU;
				alu_sel = SEL_ARITH;
			end
			F3_XOR: begin
				alu_op  = ALU_XOR;
				alu_sel = SEL_LOGIC;
			end
			F3_SRL: begin
				alu_op  = f7_alt ? ALU_SRA : ALU_SRL;
				alu_sel = SEL_SHIFT;
			end
			F3_OR: begin
				alu_op  = ALU_OR;
				alu_sel = SEL_LOGIC;
			end
			F3_AND: begin
				alu_op  = ALU_AND;
				alu_sel = SEL_LOGIC;
			end
			default: ;
		endcase
	end

	always_comb begin
		aluop_o     = ALU_NOP;
		alusel_o    = SEL_NOP;
		wd_o        = inst_i[11:7];
		wreg_o      = 1'b0;
		legal       = 1'b1;
		reg1_read_o = 1'b0;
		reg2_read_o = 1'b0;
		reg1_addr_o = inst_i[19:15];
		reg2_addr_o = inst_i[24:20];
		reg1_alt_o  = '0;
		reg2_alt_o  = '0;
		br_kind_o   = BR_NONE;
		br_offset_o = '0;
		case (opcode)
			OPC_OP_IMM: begin
				legal       = i_legal;
				aluop_o     = alu_op;
				alusel_o    = alu_sel;
				wreg_o      = 1'b1;
				reg1_read_o = 1'b1;
				reg2_alt_o  = is_shift ? imm_sh : imm_i;
			end
			OPC_OP: begin
				legal       = r_legal;
				aluop_o     = alu_op;
				alusel_o    = alu_sel;
				wreg_o      = 1'b1;
				reg1_read_o = 1'b1;
				reg2_read_o = 1'b1;
			end
			OPC_BRANCH: begin
				alusel_o    = SEL_JUMP_BRANCH;
				reg1_read_o = 1'b1;
				reg2_read_o = 1'b1;
				br_offset_o = imm_b;
				case (funct3)
					F3_BEQ: begin
						aluop_o   = ALU_BEQ;
						br_kind_o = BR_EQ;
					end
					F3_BNE: begin
						aluop_o   = ALU_BNE;
						br_kind_o = BR_NE;
					end
					F3_BLT: begin
						aluop_o   = ALU_BLT;
						br_kind_o = BR_LT;
					end
					F3_BGE: begin
						aluop_o   = ALU_BGE;
						br_kind_o = BR_GE;
					end
					F3_BLTU: begin
						aluop_o   = ALU_BLTU;
						br_kind_o = BR_LTU;
					end
					F3_BGEU: begin
						aluop_o   = ALU_BGEU;
						br_kind_o = BR_GEU;
					end
					default: legal = 1'b0;
				endcase
			end
			OPC_LOAD: begin
				alusel_o    = SEL_LOAD_STORE;
				wreg_o      = 1'b1;
				reg1_read_o = 1'b1;
				reg2_alt_o  = imm_i; // address offset
				case (funct3)
					F3_LB:   aluop_o = ALU_LB;
					F3_LH:   aluop_o = ALU_LH;
					F3_LW:   aluop_o = ALU_LW;
					F3_LBU:  aluop_o = ALU_LBU;
					F3_LHU:  aluop_o = ALU_LHU;
					default: legal = 1'b0; // LWU, LD
				endcase
			end
			OPC_STORE: begin
				alusel_o    = SEL_LOAD_STORE;
				reg1_read_o = 1'b1;
				reg2_read_o = 1'b1; // store data, forwarded like any operand
				case (funct3)
					F3_SB:   aluop_o = ALU_SB;
					F3_SH:   aluop_o = ALU_SH;
					F3_SW:   aluop_o = ALU_SW;
					default: legal = 1'b0; // SD
				endcase
			end
			OPC_LUI: begin
				aluop_o     = ALU_OR;
				alusel_o    = SEL_LOGIC;
				wreg_o      = 1'b1;
				reg1_read_o = 1'b1;
				reg1_addr_o = '0; // x0 | imm
				reg2_alt_o  = imm_u;
			end
			OPC_AUIPC: begin
				aluop_o    = ALU_ADD;
				alusel_o   = SEL_ARITH;
				wreg_o     = 1'b1;
				reg1_alt_o = pc_i;
				reg2_alt_o = imm_u;
			end
			OPC_JAL: begin
				aluop_o     = ALU_JAL;
				alusel_o    = SEL_JUMP_BRANCH;
				wreg_o      = 1'b1;
				wd_o        = LINK_REG;
				br_kind_o   = BR_JAL;
				br_offset_o = imm_j;
			end
			OPC_JALR: begin
				legal       = (funct3 == F3_JALR);
				aluop_o     = ALU_JALR;
				alusel_o    = SEL_JUMP_BRANCH;
				wreg_o      = 1'b1;
				wd_o        = LINK_REG;
				reg1_read_o = 1'b1;
				br_kind_o   = BR_JALR;
				br_offset_o = imm_i;
			end
			default: legal = 1'b0;
		endcase

		illegal_o = !legal;
		if (!legal) begin // squash everything that has a side effect
			aluop_o     = ALU_NOP;
			alusel_o    = SEL_NOP;
			wreg_o      = 1'b0;
			reg1_read_o = 1'b0;
			reg2_read_o = 1'b0;
			br_kind_o   = BR_NONE;
		end
	end

endmodule

//--- rtl/operand_bypass.sv
`timescale 1ns/1ps

module operand_bypass import rv_id_pkg::*; (
	input  logic      read_i,
	input  reg_addr_t addr_i,
	input  word_t     rf_data_i,
	input  word_t     alt_i,      // immediate or pc when not read
	input  logic      ex_wreg_i,
	input  reg_addr_t ex_wd_i,
	input  word_t     ex_wdata_i,
	input  aluop_t    ex_aluop_i,
	input  logic      mem_wreg_i,
	input  reg_addr_t mem_wd_i,
	input  word_t     mem_wdata_i,
	output word_t     operand_o,
	output logic      load_hazard_o
);

	logic addr_nz;
	logic ex_hit;
	logic mem_hit;

	// x0 never forwards and never stalls
	assign addr_nz = (addr_i != '0);
	assign ex_hit  = ex_wreg_i && (ex_wd_i == addr_i) && addr_nz;
	assign mem_hit = mem_wreg_i && (mem_wd_i == addr_i) && addr_nz;

	always_comb begin
		if (!read_i) begin
			operand_o = alt_i;
		end else if (ex_hit) begin
			operand_o = ex_wdata_i;  // youngest result wins
		end else if (mem_hit) begin
			operand_o = mem_wdata_i;
		end else begin
			operand_o = rf_data_i;
		end
	end

	// load data only exists after mem, so forwarding from ex is not enough
	assign load_hazard_o = read_i && addr_nz && is_load(ex_aluop_i) && (ex_wd_i == addr_i);

endmodule

//--- rtl/branch_unit.sv
`timescale 1ns/1ps

module branch_unit import rv_id_pkg::*; (
	input  word_t    pc_i,
	input  br_kind_t br_kind_i,
	input  word_t    br_offset_i,
	input  word_t    reg1_i,
	input  word_t    reg2_i,
	output logic     taken_o,
	output word_t    target_o,
	output word_t    link_addr_o
);

	logic  eq;
	logic  lt;
	logic  ltu;
	logic  is_jump;
	word_t jalr_sum;

	assign eq  = (reg1_i == reg2_i);
	assign lt  = ($signed(reg1_i) < $signed(reg2_i));
	assign ltu = (reg1_i < reg2_i);

	always_comb begin
		case (br_kind_i)
			BR_EQ:   taken_o = eq;
			BR_NE:   taken_o = !eq;
			BR_LT:   taken_o = lt;
			BR_GE:   taken_o = !lt;
			BR_LTU:  taken_o = ltu;
			BR_GEU:  taken_o = !ltu;
			BR_JAL,
			BR_JALR: taken_o = 1'b1;
			default: taken_o = 1'b0;
		endcase
	end

	assign is_jump  = (br_kind_i == BR_JAL) || (br_kind_i == BR_JALR);
	assign jalr_sum = reg1_i + br_offset_i; // rs1 after forwarding

	assign target_o = (br_kind_i == BR_JALR) ? {jalr_sum[XLEN-1:1], 1'b0}
	                                         : pc_i + br_offset_i;

	assign link_addr_o = is_jump ? pc_i + XLEN'(4) : '0;

endmodule

//--- rtl/regfile.sv
`timescale 1ns/1ps

module regfile import rv_id_pkg::*; (
	input  logic      clk_i,
	input  logic      rst_n_i,
	input  logic      we_i,
	input  reg_addr_t waddr_i,
	input  word_t     wdata_i,
	input  reg_addr_t raddr1_i,
	input  reg_addr_t raddr2_i,
	output word_t     rdata1_o,
	output word_t     rdata2_o
);

	word_t regs [NUM_REGS];

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && waddr_i != '0) begin // x0 stays zero
			regs[waddr_i] <= wdata_i;
		end
	end

	// write-first: a same-cycle writeback is visible to decode
	assign rdata1_o = (raddr1_i == '0)                  ? '0      :
	                  (we_i && waddr_i == raddr1_i)     ? wdata_i : regs[raddr1_i];
	assign rdata2_o = (raddr2_i == '0)                  ? '0      :
	                  (we_i && waddr_i == raddr2_i)     ? wdata_i : regs[raddr2_i];

endmodule

//--- rtl/id_ex_reg.sv
`timescale 1ns/1ps

module id_ex_reg import rv_id_pkg::*; (
	input  logic      clk_i,
	input  logic      rst_n_i,
	input  logic      load_i,     // valid and not stalled
	input  aluop_t    aluop_i,
	input  alusel_t   alusel_i,
	input  word_t     reg1_i,
	input  word_t     reg2_i,
	input  reg_addr_t wd_i,
	input  logic      wreg_i,
	input  logic      illegal_i,
	input  logic      branch_i,
	input  word_t     branch_target_i,
	input  word_t     link_addr_i,
	output logic      ex_valid_o,
	output aluop_t    ex_aluop_o,
	output alusel_t   ex_alusel_o,
	output word_t     ex_reg1_o,
	output word_t     ex_reg2_o,
	output reg_addr_t ex_wd_o,
	output logic      ex_wreg_o,
	output logic      ex_illegal_o,
	output logic      ex_branch_o,
	output word_t     ex_branch_target_o,
	output word_t     ex_link_addr_o
);

	// control fields, a bubble when nothing is loaded
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ex_valid_o   <= 1'b0;
			ex_aluop_o   <= ALU_NOP;
			ex_alusel_o  <= SEL_NOP;
			ex_wreg_o    <= 1'b0;
			ex_illegal_o <= 1'b0;
			ex_branch_o  <= 1'b0;
		end else begin
			ex_valid_o   <= load_i;
			ex_aluop_o   <= load_i ? aluop_i : ALU_NOP;
			ex_alusel_o  <= load_i ? alusel_i : SEL_NOP;
			ex_wreg_o    <= load_i && wreg_i;
			ex_illegal_o <= load_i && illegal_i;
			ex_branch_o  <= load_i && branch_i;
		end
	end

	// payload holds its last value across bubbles
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ex_reg1_o          <= '0;
			ex_reg2_o          <= '0;
			ex_wd_o            <= '0;
			ex_branch_target_o <= '0;
			ex_link_addr_o     <= '0;
		end else if (load_i) begin
			ex_reg1_o          <= reg1_i;
			ex_reg2_o          <= reg2_i;
			ex_wd_o            <= wd_i;
			ex_branch_target_o <= branch_target_i;
			ex_link_addr_o     <= link_addr_i;
		end
	end

endmodule

//--- rtl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import rv_id_pkg::*; (
	input  logic      clk_i,
	input  logic      rst_n_i,
	// fetch
	input  logic      inst_valid_i,
	input  word_t     pc_i,
	input  word_t     inst_i,
	// execute stage result
	input  logic      ex_wreg_i,
	input  reg_addr_t ex_wd_i,
	input  word_t     ex_wdata_i,
	input  aluop_t    ex_aluop_i,
	// memory stage result
	input  logic      mem_wreg_i,
	input  reg_addr_t mem_wd_i,
	input  word_t     mem_wdata_i,
	// writeback
	input  logic      wb_we_i,
	input  reg_addr_t wb_waddr_i,
	input  word_t     wb_wdata_i,
	output logic      stall_o,
	// to execute
	output logic      ex_valid_o,
	output aluop_t    ex_aluop_o,
	output alusel_t   ex_alusel_o,
	output word_t     ex_reg1_o,
	output word_t     ex_reg2_o,
	output reg_addr_t ex_wd_o,
	output logic      ex_wreg_o,
	output logic      ex_illegal_o,
	output logic      ex_branch_o,
	output word_t     ex_branch_target_o,
	output word_t     ex_link_addr_o
);

	aluop_t    dec_aluop;
	alusel_t   dec_alusel;
	reg_addr_t dec_wd;
	logic      dec_wreg;
	logic      dec_illegal;
	logic      reg1_read;
	logic      reg2_read;
	reg_addr_t reg1_addr;
	reg_addr_t reg2_addr;
	word_t     reg1_alt;
	word_t     reg2_alt;
	br_kind_t  br_kind;
	word_t     br_offset;
	word_t     rf_rdata1;
	word_t     rf_rdata2;
	word_t     reg1;
	word_t     reg2;
	logic      hazard1;
	logic      hazard2;
	logic      br_taken;
	word_t     br_target;
	word_t     link_addr;
	logic      load;

	assign stall_o = hazard1 | hazard2;
	assign load    = inst_valid_i & ~stall_o;

	inst_decoder u_dec (
		.pc_i, .inst_i,
		.aluop_o(dec_aluop), .alusel_o(dec_alusel), .wd_o(dec_wd), .wreg_o(dec_wreg),
		.illegal_o(dec_illegal), .reg1_read_o(reg1_read), .reg2_read_o(reg2_read),
		.reg1_addr_o(reg1_addr), .reg2_addr_o(reg2_addr),
		.reg1_alt_o(reg1_alt), .reg2_alt_o(reg2_alt),
		.br_kind_o(br_kind), .br_offset_o(br_offset)
	);

	regfile u_rf (
		.clk_i, .rst_n_i,
		.we_i(wb_we_i), .waddr_i(wb_waddr_i), .wdata_i(wb_wdata_i),
		.raddr1_i(reg1_addr), .raddr2_i(reg2_addr),
		.rdata1_o(rf_rdata1), .rdata2_o(rf_rdata2)
	);

	operand_bypass u_byp1 (
		.read_i(reg1_read), .addr_i(reg1_addr), .rf_data_i(rf_rdata1), .alt_i(reg1_alt),
		.ex_wreg_i, .ex_wd_i, .ex_wdata_i, .ex_aluop_i,
		.mem_wreg_i, .mem_wd_i, .mem_wdata_i,
		.operand_o(reg1), .load_hazard_o(hazard1)
	);

	operand_bypass u_byp2 (
		.read_i(reg2_read), .addr_i(reg2_addr), .rf_data_i(rf_rdata2), .alt_i(reg2_alt),
		.ex_wreg_i, .ex_wd_i, .ex_wdata_i, .ex_aluop_i,
		.mem_wreg_i, .mem_wd_i, .mem_wdata_i,
		.operand_o(reg2), .load_hazard_o(hazard2)
	);

	branch_unit u_br (
		.pc_i, .br_kind_i(br_kind), .br_offset_i(br_offset),
		.reg1_i(reg1), .reg2_i(reg2),
		.taken_o(br_taken), .target_o(br_target), .link_addr_o(link_addr)
	);

	id_ex_reg u_idex (
		.clk_i, .rst_n_i, .load_i(load),
		.aluop_i(dec_aluop), .alusel_i(dec_alusel), .reg1_i(reg1), .reg2_i(reg2),
		.wd_i(dec_wd), .wreg_i(dec_wreg), .illegal_i(dec_illegal), .branch_i(br_taken),
		.branch_target_i(br_target), .link_addr_i(link_addr),
		.ex_valid_o, .ex_aluop_o, .ex_alusel_o, .ex_reg1_o, .ex_reg2_o, .ex_wd_o,
		.ex_wreg_o, .ex_illegal_o, .ex_branch_o, .ex_branch_target_o, .ex_link_addr_o
	);

endmodule

//--- dv/decode_stage_sva.sv
`timescale 1ns/1ps

module decode_stage_sva import rv_id_pkg::*; (
	input logic  clk_i,
	input logic  rst_n_i,
	input logic  stall_o,
	input logic  ex_valid_o,
	input logic  ex_branch_o,
	input word_t ex_branch_target_o
);

	// a stalled instruction leaves a bubble in execute
	stall_bubble: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		stall_o |=> !ex_valid_o)
		else $error("stall was not followed by a bubble");

	branch_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		ex_branch_o |-> ex_valid_o)
		else $error("branch flagged on an invalid slot");

	target_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!ex_branch_target_o[0])
		else $error("branch target bit 0 set");

	first_after_reset: assert property (@(posedge clk_i)
		$rose(rst_n_i) |-> !ex_valid_o)
		else $error("valid output right after reset");

endmodule

//--- dv/decode_stage_tb.sv
`timescale 1ns/1ps

module decode_stage_tb import rv_id_pkg::*; ();

	logic      clk_i;
	logic      rst_n_i;
	logic      inst_valid_i;
	word_t     pc_i;
	word_t     inst_i;
	logic      ex_wreg_i;
	reg_addr_t ex_wd_i;
	word_t     ex_wdata_i;
	aluop_t    ex_aluop_i;
	logic      mem_wreg_i;
	reg_addr_t mem_wd_i;
	word_t     mem_wdata_i;
	logic      wb_we_i;
	reg_addr_t wb_waddr_i;
	word_t     wb_wdata_i;
	logic      stall_o;
	logic      ex_valid_o;
	aluop_t    ex_aluop_o;
	alusel_t   ex_alusel_o;
	word_t     ex_reg1_o;
	word_t     ex_reg2_o;
	reg_addr_t ex_wd_o;
	logic      ex_wreg_o;
	logic      ex_illegal_o;
	logic      ex_branch_o;
	word_t     ex_branch_target_o;
	word_t     ex_link_addr_o;

	logic [31:0] rng_state = 32'd4347;
	logic        stall_seen;
	int          checks;
	int          errors;
	int          test_errs;
	int          tests;
	int          cycles;

	decode_stage uut (.*);

	bind decode_stage decode_stage_sva u_sva (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .stall_o(stall_o), .ex_valid_o(ex_valid_o),
		.ex_branch_o(ex_branch_o), .ex_branch_target_o(ex_branch_target_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #10 clk_i = ~clk_i;
	end

	function automatic word_t xorshift();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	function automatic reg_addr_t rand_reg();
		return reg_addr_t'(xorshift() % 32'd31) + 5'd1; // never x0
	endfunction

	function automatic reg_addr_t next_reg(input reg_addr_t r);
		return (r == 5'd31) ? 5'd1 : r + 5'd1;
	endfunction

	// instruction formats
	function automatic word_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
			input reg_addr_t rs1, input logic [2:0] f3, input reg_addr_t rd);
		return {f7, rs2, rs1, f3, rd, OPC_OP};
	endfunction

	function automatic word_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
			input logic [2:0] f3, input reg_addr_t rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic word_t s_type(input logic [11:0] imm, input reg_addr_t rs2,
			input reg_addr_t rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
	endfunction

	function automatic word_t b_type(input logic [12:0] imm, input reg_addr_t rs2,
			input reg_addr_t rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
	endfunction

	function automatic word_t j_type(input logic [20:0] imm, input reg_addr_t rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
	endfunction

	function automatic logic [2:0] f3_of(input aluop_t op);
		case (op)
			ALU_SLL:          return F3_SLL;
			ALU_SLT:          return F3_SLT;
			ALU_SLTU:         return F3_SLTU;
			ALU_XOR:          return F3_XOR;
			ALU_SRL, ALU_SRA: return F3_SRL;
			ALU_OR:           return F3_OR;
			ALU_AND:          return F3_AND;
			default:          return F3_ADD;
		endcase
	endfunction

	function automatic logic [6:0] f7_of(input aluop_t op);
		return (op == ALU_SUB || op == ALU_SRA) ? F7_ALT : F7_BASE;
	endfunction

	function automatic alusel_t sel_of(input aluop_t op);
		if (op inside {ALU_XOR, ALU_OR, ALU_AND}) begin
			return SEL_LOGIC;
		end else if (op inside {ALU_SLL, ALU_SRL, ALU_SRA}) begin
			return SEL_SHIFT;
		end
		return SEL_ARITH;
	endfunction

	function automatic logic branch_taken(input logic [2:0] f3, input word_t a, input word_t b);
		case (f3)
			F3_BEQ:  return a == b;
			F3_BNE:  return a != b;
			F3_BLT:  return $signed(a) < $signed(b);
			F3_BGE:  return $signed(a) >= $signed(b);
			F3_BLTU: return a < b;
			default: return a >= b;
		endcase
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
			test_errs++;
		end
	endtask

	task automatic check_ctrl(input aluop_t op, input alusel_t sel, input logic wreg);
		check("ex_valid_o", 32'(ex_valid_o), 32'd1);
		check("ex_illegal_o", 32'(ex_illegal_o), 32'd0);
		check("ex_aluop_o", 32'(ex_aluop_o), 32'(op));
		check("ex_alusel_o", 32'(ex_alusel_o), 32'(sel));
		check("ex_wreg_o", 32'(ex_wreg_o), 32'(wreg));
	endtask

	task automatic report_test(input string name);
		if (test_errs == 0) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d errors", name, test_errs);
		end
		errors += test_errs;
		test_errs = 0;
		tests++;
	endtask

	// all tasks start and end 2 ns after a rising edge
	task automatic write_reg(input reg_addr_t addr, input word_t data);
		wb_we_i    = 1'b1;
		wb_waddr_i = addr;
		wb_wdata_i = data;
		@(posedge clk_i);
		#2;
		wb_we_i = 1'b0;
	endtask

	task automatic issue(input word_t pc, input word_t inst);
		pc_i         = pc;
		inst_i       = inst;
		inst_valid_i = 1'b1;
		@(negedge clk_i);
		stall_seen = stall_o; // combinational, settled mid cycle
		@(posedge clk_i);
		#2;
		inst_valid_i = 1'b0;
	endtask

	task automatic clear_fwd();
		ex_wreg_i   = 1'b0;
		ex_wd_i     = '0;
		ex_wdata_i  = '0;
		ex_aluop_i  = ALU_NOP;
		mem_wreg_i  = 1'b0;
		mem_wd_i    = '0;
		mem_wdata_i = '0;
	endtask

	task automatic test_alu_ops();
		aluop_t      iops [9];
		aluop_t      rops [10];
		reg_addr_t   rs1;
		reg_addr_t   rs2;
		reg_addr_t   rd;
		word_t       a;
		word_t       b;
		word_t       r;
		word_t       exp2;
		logic [11:0] imm;
		iops = '{ALU_ADD, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_OR, ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA};
		rops = '{ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
			ALU_OR, ALU_AND};
		foreach (iops[k]) begin
			rs1 = rand_reg();
			rd  = rand_reg();
			a   = xorshift();
			r   = xorshift();
			write_reg(rs1, a);
			if (iops[k] inside {ALU_SLL, ALU_SRL, ALU_SRA}) begin
				imm  = {f7_of(iops[k]), r[4:0]};
				exp2 = {27'b0, r[4:0]}; // shamt
			end else begin
				imm  = r[11:0];
				exp2 = {{20{r[11]}}, r[11:0]};
			end
			issue(32'h0000_1000, i_type(imm, rs1, f3_of(iops[k]), rd, OPC_OP_IMM));
			check_ctrl(iops[k], sel_of(iops[k]), 1'b1);
			check("ex_wd_o", 32'(ex_wd_o), 32'(rd));
			check("ex_reg1_o", ex_reg1_o, a);
			check("ex_reg2_o", ex_reg2_o, exp2);
		end
		foreach (rops[k]) begin
			rs1 = rand_reg();
			rs2 = next_reg(rs1);
			rd  = rand_reg();
			a   = xorshift();
			b   = xorshift();
			write_reg(rs1, a);
			write_reg(rs2, b);
			issue(32'h0000_1004, r_type(f7_of(rops[k]), rs2, rs1, f3_of(rops[k]), rd));
			check_ctrl(rops[k], sel_of(rops[k]), 1'b1);
			check("ex_wd_o", 32'(ex_wd_o), 32'(rd));
			check("ex_reg1_o", ex_reg1_o, a);
			check("ex_reg2_o", ex_reg2_o, b);
		end
		// MUL, DIV and LD have no place here
		for (int k = 0; k < 3; k++) begin
			rs1 = rand_reg();
			rd  = rand_reg();
			if (k == 0) begin
				issue(32'h0000_1008, r_type(7'b0000001, next_reg(rs1), rs1, 3'b000, rd));
			end else if (k == 1) begin
				issue(32'h0000_1008, r_type(7'b0000001, next_reg(rs1), rs1, 3'b100, rd));
			end else begin
				issue(32'h0000_1008, i_type(12'h010, rs1, 3'b011, rd, OPC_LOAD));
			end
			check("ex_valid_o", 32'(ex_valid_o), 32'd1);
			check("ex_illegal_o", 32'(ex_illegal_o), 32'd1);
			check("ex_wreg_o", 32'(ex_wreg_o), 32'd0);
			check("ex_branch_o", 32'(ex_branch_o), 32'd0);
		end
		report_test("alu decode");
	endtask

	task automatic test_forwarding();
		reg_addr_t rs;
		word_t     a;
		word_t     b;
		word_t     c;
		rs = rand_reg();
		a  = xorshift();
		b  = xorshift();
		c  = xorshift();
		write_reg(rs, a);
		ex_wreg_i   = 1'b1;
		ex_wd_i     = rs;
		ex_wdata_i  = b;
		ex_aluop_i  = ALU_ADD;
		mem_wreg_i  = 1'b1;
		mem_wd_i    = rs;
		mem_wdata_i = c;
		issue(32'h0000_2000, i_type(12'h000, rs, F3_ADD, 5'd3, OPC_OP_IMM));
		check("ex_reg1_o", ex_reg1_o, b);
		ex_wreg_i = 1'b0;
		issue(32'h0000_2004, i_type(12'h000, rs, F3_ADD, 5'd3, OPC_OP_IMM));
		check("ex_reg1_o", ex_reg1_o, c);
		mem_wreg_i = 1'b0;
		issue(32'h0000_2008, i_type(12'h000, rs, F3_ADD, 5'd3, OPC_OP_IMM));
		check("ex_reg1_o", ex_reg1_o, a);
		// both sources aimed at x0
		ex_wreg_i  = 1'b1;
		ex_wd_i    = '0;
		mem_wreg_i = 1'b1;
		mem_wd_i   = '0;
		issue(32'h0000_200c, i_type(12'h000, 5'd0, F3_ADD, 5'd3, OPC_OP_IMM));
		check("ex_reg1_o", ex_reg1_o, 32'd0);
		clear_fwd();
		report_test("forwarding");
	endtask

	task automatic test_load_use();
		reg_addr_t rs;
		reg_addr_t rs2;
		word_t     b;
		rs  = rand_reg();
		rs2 = next_reg(rs);
		b   = xorshift();
		ex_wreg_i  = 1'b1;
		ex_wd_i    = rs;
		ex_wdata_i = b;
		ex_aluop_i = ALU_LW;
		issue(32'h0000_3000, r_type(F7_BASE, rs2, rs, F3_ADD, 5'd4));
		check("stall_o", 32'(stall_seen), 32'd1);
		check("ex_valid_o", 32'(ex_valid_o), 32'd0);
		issue(32'h0000_3000, r_type(F7_BASE, rs, rs2, F3_ADD, 5'd4)); // hazard on rs2
		check("stall_o", 32'(stall_seen), 32'd1);
		check("ex_valid_o", 32'(ex_valid_o), 32'd0);
		ex_aluop_i = ALU_ADD;
		issue(32'h0000_3000, r_type(F7_BASE, rs2, rs, F3_ADD, 5'd4));
		check("stall_o", 32'(stall_seen), 32'd0);
		check("ex_valid_o", 32'(ex_valid_o), 32'd1);
		check("ex_reg1_o", ex_reg1_o, b);
		ex_aluop_i = ALU_LW;
		ex_wd_i    = '0;
		issue(32'h0000_3004, r_type(F7_BASE, rs2, 5'd0, F3_ADD, 5'd4));
		check("stall_o", 32'(stall_seen), 32'd0);
		check("ex_valid_o", 32'(ex_valid_o), 32'd1);
		check("ex_reg1_o", ex_reg1_o, 32'd0);
		clear_fwd();
		report_test("load-use");
	endtask

	task automatic test_branches();
		logic [2:0]  f3s [6];
		aluop_t      bops [6];
		reg_addr_t   rs1;
		reg_addr_t   rs2;
		word_t       a;
		word_t       b;
		word_t       r;
		word_t       pc;
		logic [12:0] off;
		logic        taken;
		f3s  = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
		bops = '{ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU};
		for (int k = 0; k < 6; k++) begin
			for (int v = 0; v < 4; v++) begin
				rs1 = rand_reg();
				rs2 = next_reg(rs1);
				a   = xorshift();
				b   = xorshift();
				case (v)
					1: b = a;
					2: begin // a negative, b positive
						a[31] = 1'b1;
						b[31] = 1'b0;
					end
					3: begin
						a[31] = 1'b0;
						b[31] = 1'b1;
					end
					default: ;
				endcase
				r     = xorshift();
				off   = {r[12:1], 1'b0};
				r     = xorshift();
				pc    = r & 32'hffff_fffc;
				taken = branch_taken(f3s[k], a, b);
				write_reg(rs1, a);
				write_reg(rs2, b);
				issue(pc, b_type(off, rs2, rs1, f3s[k]));
				check_ctrl(bops[k], SEL_JUMP_BRANCH, 1'b0);
				check("ex_branch_o", 32'(ex_branch_o), 32'(taken));
				if (taken) begin
					check("ex_branch_target_o", ex_branch_target_o,
						pc + {{19{off[12]}}, off});
				end
			end
		end
		report_test("branches");
	endtask

	task automatic test_jumps_misc();
		reg_addr_t   rs1;
		reg_addr_t   rs2;
		reg_addr_t   rd;
		word_t       a;
		word_t       b;
		word_t       r;
		word_t       pc;
		word_t       inst;
		logic [20:0] joff;
		logic [11:0] imm;
		r    = xorshift();
		pc   = r & 32'hffff_fffc;
		r    = xorshift();
		joff = {r[20:1], 1'b0};
		rd   = rand_reg();
		issue(pc, j_type(joff, rd));
		check_ctrl(ALU_JAL, SEL_JUMP_BRANCH, 1'b1);
		check("ex_wd_o", 32'(ex_wd_o), 32'd1);
		check("ex_branch_o", 32'(ex_branch_o), 32'd1);
		check("ex_link_addr_o", ex_link_addr_o, pc + 32'd4);
		check("ex_branch_target_o", ex_branch_target_o, pc + {{11{joff[20]}}, joff});
		// jalr base comes from execute, not from the register file
		rs1 = rand_reg();
		a   = xorshift();
		b   = xorshift();
		r   = xorshift();
		imm = r[11:0];
		write_reg(rs1, a);
		ex_wreg_i  = 1'b1;
		ex_wd_i    = rs1;
		ex_wdata_i = b;
		ex_aluop_i = ALU_ADD;
		issue(pc, i_type(imm, rs1, F3_JALR, rd, OPC_JALR));
		check_ctrl(ALU_JALR, SEL_JUMP_BRANCH, 1'b1);
		check("ex_wd_o", 32'(ex_wd_o), 32'd1);
		check("ex_branch_o", 32'(ex_branch_o), 32'd1);
		check("ex_link_addr_o", ex_link_addr_o, pc + 32'd4);
		check("ex_branch_target_o", ex_branch_target_o,
			(b + {{20{imm[11]}}, imm}) & 32'hffff_fffe);
		r    = xorshift();
		inst = {r[31:12], rd, OPC_LUI};
		ex_wd_i    = inst[19:15]; // bait on the bits where rs1 would sit
		ex_wdata_i = xorshift();
		issue(pc, inst);
		check("ex_wreg_o", 32'(ex_wreg_o), 32'd1);
		check("ex_wd_o", 32'(ex_wd_o), 32'(rd));
		check("ex_reg1_o", ex_reg1_o, 32'd0);
		check("ex_reg2_o", ex_reg2_o, {r[31:12], 12'b0});
		clear_fwd();
		r = xorshift();
		issue(pc, {r[31:12], rd, OPC_AUIPC});
		check("ex_wreg_o", 32'(ex_wreg_o), 32'd1);
		check("ex_reg1_o", ex_reg1_o, pc);
		check("ex_reg2_o", ex_reg2_o, {r[31:12], 12'b0});
		// store data forwarded from memory stage
		rs1 = rand_reg();
		rs2 = next_reg(rs1);
		a   = xorshift();
		write_reg(rs1, a);
		write_reg(rs2, xorshift());
		b           = xorshift();
		mem_wreg_i  = 1'b1;
		mem_wd_i    = rs2;
		mem_wdata_i = b;
		issue(pc, s_type(12'h024, rs2, rs1, F3_SW));
		check_ctrl(ALU_SW, SEL_LOAD_STORE, 1'b0);
		check("ex_reg1_o", ex_reg1_o, a);
		check("ex_reg2_o", ex_reg2_o, b);
		clear_fwd();
		report_test("jumps, lui, auipc, store");
	endtask

	// about ten times the length of the directed run
	initial begin
		cycles = 0;
		while (cycles < 2000) begin
			@(posedge clk_i);
			cycles++;
		end
		$display("timeout: the tests did not finish within %0d cycles", cycles);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		rst_n_i      = 1'b0;
		inst_valid_i = 1'b0;
		pc_i         = '0;
		inst_i       = '0;
		wb_we_i      = 1'b0;
		wb_waddr_i   = '0;
		wb_wdata_i   = '0;
		checks       = 0;
		errors       = 0;
		test_errs    = 0;
		tests        = 0;
		clear_fwd();
		repeat (10) @(posedge clk_i);
		#2;
		rst_n_i = 1'b1;
		test_alu_ops();
		test_forwarding();
		test_load_use();
		test_branches();
		test_jumps_misc();
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- rv_decode.f
rtl/rv_id_pkg.sv
rtl/inst_decoder.sv
rtl/operand_bypass.sv
rtl/branch_unit.sv
rtl/regfile.sv
rtl/id_ex_reg.sv
rtl/decode_stage.sv
dv/decode_stage_sva.sv
dv/decode_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# build with verilator, run, then judge the log
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -f rv_decode.f --top-module decode_stage_tb \
	-o decode_stage_sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/decode_stage_sim > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log
grep -q "Simulation failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Simulation completed successfully" sim.log && echo "PASS" || { echo "FAIL, run did not finish"; exit 1; }
